/* Bender.yml */
package:
  name: serial_bus

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/serial_bus_pkg.sv
      - rtl/bus_master.sv
      - rtl/slave_mem.sv
      - rtl/serial_bus_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/serial_bus_tb.sv

/* include/serial_bus_config.svh */
/*
  Serial memory bus configuration.
  Word and address widths, slave count, burst limits and the
  control frame layout shared by the master, slaves and testbench.
*/
`ifndef SERIAL_BUS_CONFIG_SVH
`define SERIAL_BUS_CONFIG_SVH

// data path
`define SB_DATA_WIDTH      32
`define SB_WORD_CNT_WIDTH  6

// slave memories
`define SB_ADDR_DEPTH      256
`define SB_ADDR_WIDTH      8
`define SB_NUM_SLAVES      3
`define SB_SID_WIDTH       2

// burst length, 1 to SB_MAX_BEATS words
`define SB_MAX_BEATS       8
`define SB_BEAT_WIDTH      4

// control frame: start | slave id | write | burst | start address
`define SB_START_PATTERN   3'b111
`define SB_CTRL_LEN        15

`endif

/* rtl/bus_master.sv */
/*
  Serial bus master.
  Takes one parallel host request at a time, sends it as a serial
  control frame, then shifts write words out or collects read words,
  one bit per clock, most significant bit first.
*/
`default_nettype none

`include "serial_bus_config.svh"

module bus_master (
    input  logic                     clk,
    input  logic                     rstN,
    input  serial_bus_pkg::bus_req_t req,
    input  logic                     req_valid,
    input  serial_bus_pkg::word_t    wdata,
    input  logic                     rd,
    input  logic                     ready,
    output logic                     busy,
    output logic                     wdata_take,
    output serial_bus_pkg::word_t    rdata,
    output logic                     rdata_valid,
    output logic                     done,
    output logic                     control,
    output logic                     wd,
    output logic                     valid,
    output logic                     last
);

    localparam int CNT_W = `SB_WORD_CNT_WIDTH;

    typedef logic [CNT_W-1:0] cnt_t;

    localparam cnt_t FRAME_LAST = cnt_t'(`SB_CTRL_LEN - 1);
    localparam cnt_t WORD_LAST  = cnt_t'(`SB_DATA_WIDTH - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_FRAME,
        S_WRITE,
        S_READ
    } state_t;

    state_t                      state;
    cnt_t                        bit_cnt;
    logic [`SB_BEAT_WIDTH-1:0]   beats_left;
    logic                        is_write;
    logic                        take_req;
    logic                        frame_end;
    serial_bus_pkg::ctrl_frame_t req_frame;
    serial_bus_pkg::ctrl_frame_t frame_sr;
    serial_bus_pkg::word_t       wr_sr;

    // frame built straight from the host request
    always_comb begin
        req_frame.start    = `SB_START_PATTERN;
        req_frame.slave_id = req.slave_id;
        req_frame.write    = req.write;
        req_frame.burst    = (req.beats > 1);
        req_frame.addr     = req.addr;
    end

    assign take_req  = (state == S_IDLE) && req_valid;
    assign frame_end = (state == S_FRAME) && (bit_cnt == '0);
    assign busy      = (state != S_IDLE);

    // next write word is latched at the end of the frame and after each word
    assign wdata_take = (frame_end && is_write) ||
                        ((state == S_WRITE) && (bit_cnt == '0) && (beats_left != 1));

    // bus lines, low whenever no bit is being sent
    assign control = (state == S_FRAME) && frame_sr[`SB_CTRL_LEN-1];
    assign wd      = valid && wr_sr[`SB_DATA_WIDTH-1];

    // bit_cnt counts down the bits left in the current frame or word
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state       <= S_IDLE;
            bit_cnt     <= '0;
            beats_left  <= '0;
            is_write    <= 1'b0;
            valid       <= 1'b0;
            last        <= 1'b0;
            done        <= 1'b0;
            rdata_valid <= 1'b0;
        end else begin
            done        <= 1'b0;
            rdata_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (take_req) begin
                        bit_cnt    <= FRAME_LAST;
                        beats_left <= req.beats;
                        is_write   <= req.write;
                        state      <= S_FRAME;
                    end
                end
                S_FRAME: begin
                    if (bit_cnt != '0) begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end else begin
                        bit_cnt <= WORD_LAST;
                        if (is_write) begin
                            valid <= 1'b1;
                            state <= S_WRITE;
                        end else begin
                            // reads hold last over the whole final word
                            last  <= (beats_left == 1);
                            state <= S_READ;
                        end
                    end
                end
                S_WRITE: begin
                    if (bit_cnt != '0) begin
                        bit_cnt <= bit_cnt - 1'b1;
                        last    <= (bit_cnt == 1) && (beats_left == 1);
                    end else if (beats_left != 1) begin
                        bit_cnt    <= WORD_LAST;
                        beats_left <= beats_left - 1'b1;
                    end else begin
                        valid <= 1'b0;
                        last  <= 1'b0;
                        done  <= 1'b1;
                        state <= S_IDLE;
                    end
                end
                S_READ: begin
                    // slave fetch cycles show up as ready low
                    if (ready) begin
                        if (bit_cnt != '0) begin
                            bit_cnt <= bit_cnt - 1'b1;
                        end else begin
                            bit_cnt     <= WORD_LAST;
                            rdata_valid <= 1'b1;
                            if (beats_left == 1) begin
                                last  <= 1'b0;
                                done  <= 1'b1;
                                state <= S_IDLE;
                            end else begin
                                beats_left <= beats_left - 1'b1;
                                last       <= (beats_left == 2);
                            end
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // frame, write and read shift registers
    always_ff @(posedge clk) begin
        if (take_req) begin
            frame_sr <= req_frame;
        end else if (state == S_FRAME) begin
            frame_sr <= serial_bus_pkg::ctrl_frame_t'({frame_sr[`SB_CTRL_LEN-2:0], 1'b0});
        end

        if (wdata_take) begin
            wr_sr <= wdata;
        end else if (valid) begin
            wr_sr <= {wr_sr[`SB_DATA_WIDTH-2:0], 1'b0};
        end

        // rdata stays put during rdata_valid, the slave is fetching then
        if ((state == S_READ) && ready) begin
            rdata <= {rdata[`SB_DATA_WIDTH-2:0], rd};
        end
    end

endmodule

`default_nettype wire

/* rtl/serial_bus_pkg.sv */
/*
  Serial memory bus types.
  Data word, address and slave id types, the host request and the
  serial control frame exchanged between master and slaves.
*/
`default_nettype none

`include "serial_bus_config.svh"

package serial_bus_pkg;

    typedef logic [`SB_DATA_WIDTH-1:0] word_t;
    typedef logic [`SB_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`SB_SID_WIDTH-1:0]  slave_id_t;

    // fields in transmission order, start bits go out first
    typedef struct packed {
        logic [$bits(`SB_START_PATTERN)-1:0] start;
        slave_id_t                           slave_id;
        logic                                write;
        logic                                burst;
        addr_t                               addr;
    } ctrl_frame_t;

    // host request, beats counts words from 1 upwards
    typedef struct packed {
        slave_id_t                  slave_id;
        logic                       write;
        addr_t                      addr;
        logic [`SB_BEAT_WIDTH-1:0]  beats;
    } bus_req_t;

endpackage

`default_nettype wire

/* rtl/serial_bus_top.sv */
/*
  Serial memory bus subsystem.
  One bus master and three slave memories. Master outputs are
  broadcast to every slave, slave responses are ORed back.
*/
`default_nettype none

`include "serial_bus_config.svh"

module serial_bus_top (
    input  logic                     clk,
    input  logic                     rstN,
    input  serial_bus_pkg::bus_req_t req,
    input  logic                     req_valid,
    input  serial_bus_pkg::word_t    wdata,
    output logic                     busy,
    output logic                     wdata_take,
    output serial_bus_pkg::word_t    rdata,
    output logic                     rdata_valid,
    output logic                     done
);

    logic                      control;
    logic                      wd;
    logic                      valid;
    logic                      last;
    logic                      rd;
    logic                      ready;
    logic [`SB_NUM_SLAVES-1:0] slave_rd;
    logic [`SB_NUM_SLAVES-1:0] slave_ready;

    // only the addressed slave drives nonzero
    assign rd    = |slave_rd;
    assign ready = |slave_ready;

    bus_master master (
        .clk         (clk),
        .rstN        (rstN),
        .req         (req),
        .req_valid   (req_valid),
        .wdata       (wdata),
        .rd          (rd),
        .ready       (ready),
        .busy        (busy),
        .wdata_take  (wdata_take),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .done        (done),
        .control     (control),
        .wd          (wd),
        .valid       (valid),
        .last        (last)
    );

    slave_mem #(.SLAVE_ID(0)) slave0 (
        .clk     (clk),
        .rstN    (rstN),
        .control (control),
        .wd      (wd),
        .valid   (valid),
        .last    (last),
        .rd      (slave_rd[0]),
        .ready   (slave_ready[0])
    );

    slave_mem #(.SLAVE_ID(1)) slave1 (
        .clk     (clk),
        .rstN    (rstN),
        .control (control),
        .wd      (wd),
        .valid   (valid),
        .last    (last),
        .rd      (slave_rd[1]),
        .ready   (slave_ready[1])
    );

    slave_mem #(.SLAVE_ID(2)) slave2 (
        .clk     (clk),
        .rstN    (rstN),
        .control (control),
        .wd      (wd),
        .valid   (valid),
        .last    (last),
        .rd      (slave_rd[2]),
        .ready   (slave_ready[2])
    );

endmodule

`default_nettype wire

/* rtl/slave_mem.sv */
/*
  Serial bus slave memory.
  Decodes broadcast control frames, answers only its own slave id,
  stores serial write words and streams words back on reads.
  Bursts step the address by one word per beat.
*/
`default_nettype none

`include "serial_bus_config.svh"

module slave_mem #(
    parameter int SLAVE_ID = 0
) (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic wd,
    input  logic valid,
    input  logic last,
    output logic rd,
    output logic ready
);

    localparam int CNT_W = `SB_WORD_CNT_WIDTH;

    typedef logic [CNT_W-1:0] cnt_t;

    localparam cnt_t FRAME_LAST = cnt_t'(`SB_CTRL_LEN - 1);
    localparam cnt_t WORD_LAST  = cnt_t'(`SB_DATA_WIDTH - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FRAME,
        S_WRITE,
        S_FETCH,
        S_SEND
    } state_t;

    state_t                      state;
    cnt_t                        bit_cnt;
    serial_bus_pkg::ctrl_frame_t frame_q;
    serial_bus_pkg::ctrl_frame_t frame_next;
    serial_bus_pkg::addr_t       addr;
    serial_bus_pkg::word_t       wr_sr;
    serial_bus_pkg::word_t       wr_next;
    serial_bus_pkg::word_t       rd_sr;
    logic                        frame_hit;
    logic                        word_done;
    logic                        burst_end;

    serial_bus_pkg::word_t mem [`SB_ADDR_DEPTH];

    // frame register with the current control bit shifted in
    assign frame_next = serial_bus_pkg::ctrl_frame_t'({frame_q[`SB_CTRL_LEN-2:0], control});

    // start pattern and own id both have to match
    assign frame_hit = (frame_next.start == `SB_START_PATTERN) &&
                       (frame_next.slave_id == serial_bus_pkg::slave_id_t'(SLAVE_ID));

    assign word_done = (bit_cnt == WORD_LAST);
    assign burst_end = last || !frame_q.burst;
    assign wr_next   = {wr_sr[`SB_DATA_WIDTH-2:0], wd};

    // rd stays zero unless this slave is sending
    assign rd = ready && rd_sr[`SB_DATA_WIDTH-1];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= S_IDLE;
            bit_cnt <= '0;
            frame_q <= '0;
            addr    <= '0;
            ready   <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    // every frame begins with a 1
                    if (control) begin
                        frame_q <= frame_next;
                        bit_cnt <= cnt_t'(1);
                        state   <= S_FRAME;
                    end
                end
                S_FRAME: begin
                    frame_q <= frame_next;
                    if (bit_cnt == FRAME_LAST) begin
                        bit_cnt <= '0;
                        if (frame_hit) begin
                            addr  <= frame_next.addr;
                            state <= frame_next.write ? S_WRITE : S_FETCH;
                        end else begin
                            // frame for another slave
                            state <= S_IDLE;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                S_WRITE: begin
                    if (valid) begin
                        if (word_done) begin
                            bit_cnt <= '0;
                            addr    <= addr + 1'b1;
                            if (burst_end) begin
                                state <= S_IDLE;
                            end
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                S_FETCH: begin
                    // one cycle for the memory read, ready low
                    bit_cnt <= '0;
                    ready   <= 1'b1;
                    state   <= S_SEND;
                end
                S_SEND: begin
                    if (word_done) begin
                        bit_cnt <= '0;
                        ready   <= 1'b0;
                        if (burst_end) begin
                            state <= S_IDLE;
                        end else begin
                            addr  <= addr + 1'b1;
                            state <= S_FETCH;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // word memory and data shift registers
    always_ff @(posedge clk) begin
        if ((state == S_WRITE) && valid) begin
            wr_sr <= wr_next;
            if (word_done) begin
                mem[addr] <= wr_next;
            end
        end

        if (state == S_FETCH) begin
            rd_sr <= mem[addr];
        end else if (state == S_SEND) begin
            rd_sr <= {rd_sr[`SB_DATA_WIDTH-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

/* serial_bus_top.f */
+incdir+include
rtl/serial_bus_pkg.sv
rtl/bus_master.sv
rtl/slave_mem.sv
rtl/serial_bus_top.sv
verif/serial_bus_tb.sv

/* verif/serial_bus_tb.sv */
/*
  Testbench for the serial memory bus.
  Directed tests and a seeded random run through the host port.
  Every read is predicted by a reference memory per slave.
*/
`default_nettype none

`include "serial_bus_config.svh"

module serial_bus_tb;

    typedef logic [`SB_BEAT_WIDTH-1:0] beats_t;

    // budget covers frame and overhead per transaction and 33 cycles per word
    localparam int NUM_XACTS      = 35;
    localparam int NUM_BEATS      = 181;
    localparam int TIMEOUT_CYCLES = NUM_XACTS * (`SB_CTRL_LEN + 4) +
                                    NUM_BEATS * (`SB_DATA_WIDTH + 1) + 200;
    localparam int RAND_WINDOW    = 40;

    logic                     clk;
    logic                     rstN;
    serial_bus_pkg::bus_req_t req;
    logic                     req_valid;
    serial_bus_pkg::word_t    wdata;
    logic                     busy;
    logic                     wdata_take;
    serial_bus_pkg::word_t    rdata;
    logic                     rdata_valid;
    logic                     done;

    integer                   seed;
    int                       error_count;
    int                       num_checks;
    int                       write_cycles;
    serial_bus_pkg::word_t    wr_buf [`SB_MAX_BEATS];
    serial_bus_pkg::word_t    rd_buf [`SB_MAX_BEATS];
    serial_bus_pkg::word_t    ref_mem [`SB_NUM_SLAVES][`SB_ADDR_DEPTH];
    logic                     ref_known [`SB_NUM_SLAVES][`SB_ADDR_DEPTH];

    serial_bus_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: transactions did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic check_word(input serial_bus_pkg::word_t got,
                              input serial_bus_pkg::word_t exp, input string what);
        num_checks++;
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        num_checks++;
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_int(input int got, input int exp, input string what);
        num_checks++;
        if (got != exp) begin
            error_count++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // master is idle here and takes the request on the next rising edge
    task automatic send_req(input int sid, input logic write, input int addr, input int beats);
        req.slave_id = serial_bus_pkg::slave_id_t'(sid);
        req.write    = write;
        req.addr     = serial_bus_pkg::addr_t'(addr);
        req.beats    = beats_t'(beats);
        req_valid    = 1'b1;
        @(negedge clk);
        req_valid    = 1'b0;
    endtask

    task automatic do_write(input int sid, input int addr, input int beats);
        int   idx;
        int   takes;
        int   i;
        logic pending;
        idx          = 0;
        takes        = 0;
        pending      = 1'b0;
        wdata        = wr_buf[0];
        send_req(sid, 1'b1, addr, beats);
        write_cycles = 1;
        while (!done) begin
            @(negedge clk);
            write_cycles++;
            // next word goes up once the master has latched the current one
            if (pending && idx + 1 < beats) begin
                idx++;
                wdata = wr_buf[idx];
            end
            pending = wdata_take;
            if (wdata_take) begin
                takes++;
            end
        end
        check_int(takes, beats, "write words taken");
        for (i = 0; i < beats; i++) begin
            ref_mem[sid][addr + i]   = wr_buf[i];
            ref_known[sid][addr + i] = 1'b1;
        end
    endtask

    task automatic do_read(input int sid, input int addr, input int beats);
        int got;
        int i;
        got = 0;
        send_req(sid, 1'b0, addr, beats);
        // final word arrives together with done
        while (!done) begin
            @(negedge clk);
            if (rdata_valid) begin
                if (got < `SB_MAX_BEATS) begin
                    rd_buf[got] = rdata;
                end
                got++;
            end
        end
        check_int(got, beats, "read words returned");
        for (i = 0; i < beats && i < got; i++) begin
            // words never written hold no defined value
            if (ref_known[sid][addr + i]) begin
                check_word(rd_buf[i], ref_mem[sid][addr + i],
                           $sformatf("slave %0d addr %0d", sid, addr + i));
            end
        end
    endtask

    task automatic reset_and_write_latency();
        check_bit(busy, 1'b0, "busy after reset");
        check_bit(done, 1'b0, "done after reset");
        check_bit(rdata_valid, 1'b0, "rdata_valid after reset");
        check_bit(wdata_take, 1'b0, "wdata_take after reset");
        wr_buf[0] = 32'h1234_5678;
        do_write(0, 5, 1);
        check_int(write_cycles, `SB_CTRL_LEN + 33, "single write latency");
        check_bit(busy, 1'b0, "busy with done");
        @(negedge clk);
        check_bit(done, 1'b0, "done one cycle later");
        check_bit(busy, 1'b0, "busy after done");
    endtask

    task automatic single_readback();
        wr_buf[0] = 32'hcafe_0042;
        do_write(2, 100, 1);
        do_read(2, 100, 1);
        check_word(rd_buf[0], 32'hcafe_0042, "single readback");
    endtask

    task automatic burst_readback();
        serial_bus_pkg::word_t words [4];
        int                    i;
        for (i = 0; i < 4; i++) begin
            words[i]  = 32'h9e37_79b9 * (i + 1);
            wr_buf[i] = words[i];
        end
        do_write(1, 10, 4);
        do_read(1, 10, 4);
        for (i = 0; i < 4; i++) begin
            check_word(rd_buf[i], words[i], $sformatf("burst word %0d", i));
        end
        // single reads show the slave stepped the address per word
        for (i = 0; i < 4; i++) begin
            do_read(1, 10 + i, 1);
            check_word(rd_buf[0], words[i], $sformatf("single read addr %0d", 10 + i));
        end
    endtask

    task automatic slave_id_decode();
        int s;
        for (s = 0; s < `SB_NUM_SLAVES; s++) begin
            wr_buf[0] = 32'h5100_0000 + s;
            do_write(s, 20, 1);
        end
        for (s = 0; s < `SB_NUM_SLAVES; s++) begin
            do_read(s, 20, 1);
            check_word(rd_buf[0], 32'h5100_0000 + s, $sformatf("slave %0d addr 20", s));
        end
    endtask

    task automatic random_traffic();
        int   n;
        int   i;
        int   sid;
        int   beats;
        int   addr;
        logic write;
        for (n = 0; n < 20; n++) begin
            sid   = $unsigned($random(seed)) % `SB_NUM_SLAVES;
            beats = 1 + $unsigned($random(seed)) % `SB_MAX_BEATS;
            // small window so reads mostly land on written words
            addr  = $unsigned($random(seed)) % (RAND_WINDOW - beats + 1);
            write = ($random(seed) & 1) != 0;
            if (write) begin
                for (i = 0; i < beats; i++) begin
                    wr_buf[i] = $random(seed);
                end
                do_write(sid, addr, beats);
            end else begin
                do_read(sid, addr, beats);
            end
        end
    endtask

    initial begin
        int s;
        int a;
        seed        = 32'h010d8866;
        error_count = 0;
        num_checks  = 0;
        rstN        = 1'b0;
        req         = '0;
        req_valid   = 1'b0;
        wdata       = '0;
        for (s = 0; s < `SB_NUM_SLAVES; s++) begin
            for (a = 0; a < `SB_ADDR_DEPTH; a++) begin
                ref_known[s][a] = 1'b0;
            end
        end
        repeat (3) @(negedge clk);
        rstN = 1'b1;
        reset_and_write_latency();
        single_readback();
        burst_readback();
        slave_id_decode();
        random_traffic();
        $display("checks %0d, errors %0d", num_checks, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
